// ==== src/tscPkg.sv ====
/*
 * Shared TSC definitions: widths, opcode and function codes,
 * ALU and FSM encodings, instruction views, control word and memory bus
 */
package tscPkg;

    localparam int WordSize     = 16;
    localparam int RegAddrWidth = 2;

    // Opcode field, bits 15:12
    localparam logic [3:0] OpBne   = 4'd0;
    localparam logic [3:0] OpBeq   = 4'd1;
    localparam logic [3:0] OpBgz   = 4'd2;
    localparam logic [3:0] OpBlz   = 4'd3;
    localparam logic [3:0] OpAdi   = 4'd4;
    localparam logic [3:0] OpOri   = 4'd5;
    localparam logic [3:0] OpLhi   = 4'd6;
    localparam logic [3:0] OpLwd   = 4'd7;
    localparam logic [3:0] OpSwd   = 4'd8;
    localparam logic [3:0] OpJmp   = 4'd9;
    localparam logic [3:0] OpRtype = 4'd15;

    // R-type function field, bits 5:0
    localparam logic [5:0] FuncAdd = 6'd0;
    localparam logic [5:0] FuncSub = 6'd1;
    localparam logic [5:0] FuncAnd = 6'd2;
    localparam logic [5:0] FuncOrr = 6'd3;
    localparam logic [5:0] FuncNot = 6'd4;
    localparam logic [5:0] FuncTcp = 6'd5;
    localparam logic [5:0] FuncShl = 6'd6;
    localparam logic [5:0] FuncShr = 6'd7;
    localparam logic [5:0] FuncJpr = 6'd25;
    localparam logic [5:0] FuncWwd = 6'd28;
    localparam logic [5:0] FuncHlt = 6'd29;

    typedef enum logic [3:0] {
        AluAdd, AluSub, AluPassB, AluNot, AluAnd, AluOr, AluShr, AluShl, AluTcp
    } aluOp_t;

    typedef enum logic [2:0] {StIf, StId, StEx, StMem, StWb} state_t;

    typedef enum logic [1:0] {SrcReg, SrcOne, SrcImm, SrcHigh} aluSrcB_t;  // SrcHigh is imm << 8
    typedef enum logic [1:0] {PcAlu, PcAluOut, PcJump, PcReg} pcSrc_t;

    // One fetched word, three decodings
    typedef union packed {
        struct packed {
            logic [3:0]              opcode;
            logic [RegAddrWidth-1:0] rs;
            logic [RegAddrWidth-1:0] rt;
            logic [RegAddrWidth-1:0] rd;
            logic [5:0]              func;
        } rType;
        struct packed {
            logic [3:0]              opcode;
            logic [RegAddrWidth-1:0] rs;
            logic [RegAddrWidth-1:0] rt;
            logic [7:0]              imm8;
        } iType;
        struct packed {
            logic [3:0]  opcode;
            logic [11:0] target12;
        } jType;
    } instr_t;

    // Sequencer to datapath, one word per cycle
    typedef struct packed {
        logic     pcWrite;
        logic     pcWriteCond;  // Taken branch
        logic     iorD;         // Address from ALUOut
        logic     irWrite;
        logic     mdrWrite;
        logic     abWrite;
        logic     aluOutWrite;
        logic     aluSrcA;      // 1 selects A, 0 selects PC
        aluSrcB_t aluSrcB;
        aluOp_t   aluOp;
        pcSrc_t   pcSource;
        logic     regWrite;
        logic     regDst;       // 1 selects rd, 0 selects rt
        logic     memToReg;
        logic     outWrite;
        logic     zeroExt;
    } ctrl_t;

    typedef struct packed {
        logic                readM;
        logic                writeM;
        logic [WordSize-1:0] address;
        logic [WordSize-1:0] writeData;
    } memReq_t;

endpackage

// ==== src/tscAlu.sv ====
/*
 * Combinational ALU for the TSC instruction subset
 */
`timescale 1ns/100ps

module tscAlu (
    input  logic [tscPkg::WordSize-1:0] operandA,
    input  logic [tscPkg::WordSize-1:0] operandB,
    input  tscPkg::aluOp_t              op,
    output logic [tscPkg::WordSize-1:0] result
);

    always_comb begin
        case (op)
            tscPkg::AluAdd:   result = operandA + operandB;
            tscPkg::AluSub:   result = operandA - operandB;
            tscPkg::AluPassB: result = operandB;               // LHI
            tscPkg::AluNot:   result = ~operandA;
            tscPkg::AluAnd:   result = operandA & operandB;
            tscPkg::AluOr:    result = operandA | operandB;
            tscPkg::AluShr:   result = $signed(operandA) >>> 1;  // Keeps sign bit
            tscPkg::AluShl:   result = operandA << 1;
            tscPkg::AluTcp:   result = ~operandA + 1'b1;
            default:          result = '0;
        endcase
    end

endmodule

// ==== src/tscRegFile.sv ====
/*
 * Four-entry register file, two combinational reads, one clocked write
 */
`timescale 1ns/100ps

module tscRegFile (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic [tscPkg::RegAddrWidth-1:0] readAddrA,
    input  logic [tscPkg::RegAddrWidth-1:0] readAddrB,
    input  logic [tscPkg::RegAddrWidth-1:0] writeAddr,
    input  logic                            writeEnable,
    input  logic [tscPkg::WordSize-1:0]     writeData,
    output logic [tscPkg::WordSize-1:0]     readDataA,
    output logic [tscPkg::WordSize-1:0]     readDataB
);

    logic [tscPkg::WordSize-1:0] regs [2**tscPkg::RegAddrWidth];  // $0 to $3

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < 2**tscPkg::RegAddrWidth; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable) begin
            regs[writeAddr] <= writeData;
        end
    end

    assign readDataA = regs[readAddrA];  // No write bypass
    assign readDataB = regs[readAddrB];

endmodule

// ==== src/tscDatapath.sv ====
/*
 * Datapath: PC, IR, A, B, ALUOut, MDR, operand and PC muxes
 * Branch condition and WWD output port
 */
`timescale 1ns/100ps

module tscDatapath #(
    parameter logic [tscPkg::WordSize-1:0] ResetPc = '0
) (
    input  logic                        clk,
    input  logic                        reset_n,
    input  tscPkg::ctrl_t               ctrl,
    input  logic [tscPkg::WordSize-1:0] readData,
    output tscPkg::instr_t              instr,
    output logic                        bcond,
    output logic [tscPkg::WordSize-1:0] address,
    output logic [tscPkg::WordSize-1:0] writeData,
    output logic [tscPkg::WordSize-1:0] outputPort
);

    localparam int Width = tscPkg::WordSize;

    tscPkg::instr_t                  ir;
    logic [Width-1:0]                pc;
    logic [Width-1:0]                a;
    logic [Width-1:0]                b;
    logic [Width-1:0]                aluOut;
    logic [Width-1:0]                mdr;
    logic [Width-1:0]                imm;        // Extended imm8
    logic [Width-1:0]                aluInA;
    logic [Width-1:0]                aluInB;
    logic [Width-1:0]                aluResult;
    logic [Width-1:0]                pcNext;
    logic [Width-1:0]                rfDataA;    // rs
    logic [Width-1:0]                rfDataB;    // rt
    logic [Width-1:0]                rfWriteData;
    logic [tscPkg::RegAddrWidth-1:0] rfWriteAddr;

    assign instr     = ir;
    assign writeData = b;
    assign address   = ctrl.iorD ? aluOut : pc;

    assign imm = ctrl.zeroExt ? {{(Width-8){1'b0}}, ir.iType.imm8}
                              : {{(Width-8){ir.iType.imm8[7]}}, ir.iType.imm8};

    assign aluInA = ctrl.aluSrcA ? a : pc;

    always_comb begin
        case (ctrl.aluSrcB)
            tscPkg::SrcReg: aluInB = b;
            tscPkg::SrcOne: aluInB = Width'(1);
            tscPkg::SrcImm: aluInB = imm;
            default:        aluInB = {ir.iType.imm8, {(Width-8){1'b0}}};  // LHI
        endcase
    end

    always_comb begin
        case (ctrl.pcSource)
            tscPkg::PcAlu:    pcNext = aluResult;
            tscPkg::PcAluOut: pcNext = aluOut;
            tscPkg::PcJump:   pcNext = {pc[Width-1:12], ir.jType.target12};
            default:          pcNext = rfDataA;  // JPR
        endcase
    end

    always_comb begin
        case (ir.iType.opcode)
            tscPkg::OpBne: bcond = a != b;
            tscPkg::OpBeq: bcond = a == b;
            tscPkg::OpBgz: bcond = !a[Width-1] && (a != '0);
            tscPkg::OpBlz: bcond = a[Width-1];
            default:       bcond = 1'b0;
        endcase
    end

    assign rfWriteAddr = ctrl.regDst ? ir.rType.rd : ir.rType.rt;
    assign rfWriteData = ctrl.memToReg ? mdr : aluOut;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc         <= ResetPc;
            ir         <= '0;
            outputPort <= '0;
        end else begin
            if (ctrl.pcWrite || ctrl.pcWriteCond) begin
                pc <= pcNext;
            end
            if (ctrl.irWrite) begin
                ir <= readData;
            end
            if (ctrl.outWrite) begin
                outputPort <= rfDataA;  // WWD shows rs in ID
            end
        end
    end

    // Staging registers
    always_ff @(posedge clk) begin
        if (ctrl.abWrite) begin
            a <= rfDataA;
            b <= rfDataB;
        end
        if (ctrl.aluOutWrite) begin
            aluOut <= aluResult;
        end
        if (ctrl.mdrWrite) begin
            mdr <= readData;
        end
    end

    tscRegFile i_regFile (
        .clk         (clk),
        .reset_n     (reset_n),
        .readAddrA   (ir.rType.rs),
        .readAddrB   (ir.rType.rt),
        .writeAddr   (rfWriteAddr),
        .writeEnable (ctrl.regWrite),
        .writeData   (rfWriteData),
        .readDataA   (rfDataA),
        .readDataB   (rfDataB)
    );

    tscAlu i_alu (
        .operandA (aluInA),
        .operandB (aluInB),
        .op       (ctrl.aluOp),
        .result   (aluResult)
    );

endmodule

// ==== src/tscSequencer.sv ====
/*
 * Multi-cycle control FSM: IF, ID, EX, MEM, WB
 * Control-word decode, retired-instruction counter, halt flag
 */
`timescale 1ns/100ps

module tscSequencer (
    input  logic                        clk,
    input  logic                        reset_n,
    input  tscPkg::instr_t              instr,
    input  logic                        bcond,
    input  logic                        inputReady,
    output tscPkg::ctrl_t               ctrl,
    output logic                        readM,
    output logic                        writeM,
    output logic [tscPkg::WordSize-1:0] numInst,
    output logic                        isHalted
);

    tscPkg::state_t state;
    tscPkg::state_t nextState;
    logic [3:0]     opcode;
    logic [5:0]     func;
    logic           isRtype;
    logic           isBranch;
    logic           idOnly;   // Finishes in ID
    logic           done;     // Retires this cycle
    logic           haltNow;

    assign opcode   = instr.rType.opcode;
    assign func     = instr.rType.func;
    assign isRtype  = opcode == tscPkg::OpRtype;
    assign isBranch = opcode inside {tscPkg::OpBne, tscPkg::OpBeq, tscPkg::OpBgz, tscPkg::OpBlz};
    assign idOnly   = (opcode == tscPkg::OpJmp)
                    || (isRtype && (func inside {tscPkg::FuncJpr, tscPkg::FuncWwd, tscPkg::FuncHlt}));
    assign haltNow  = (state == tscPkg::StId) && isRtype && (func == tscPkg::FuncHlt);

    assign done = ((state == tscPkg::StId) && idOnly)
               || ((state == tscPkg::StEx) && isBranch)
               || ((state == tscPkg::StMem) && (opcode == tscPkg::OpSwd))
               || (state == tscPkg::StWb);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state    <= tscPkg::StIf;
            numInst  <= '0;
            isHalted <= 1'b0;
        end else begin
            state <= nextState;
            if (done) begin
                numInst <= numInst + 1'b1;
            end
            if (haltNow) begin
                isHalted <= 1'b1;  // Sticky until reset
            end
        end
    end

    always_comb begin
        nextState = tscPkg::StIf;
        case (state)
            tscPkg::StIf:  nextState = (inputReady && !isHalted) ? tscPkg::StId : tscPkg::StIf;
            tscPkg::StId:  nextState = idOnly ? tscPkg::StIf : tscPkg::StEx;
            tscPkg::StEx: begin
                if (isBranch) begin
                    nextState = tscPkg::StIf;
                end else if (opcode inside {tscPkg::OpLwd, tscPkg::OpSwd}) begin
                    nextState = tscPkg::StMem;
                end else begin
                    nextState = tscPkg::StWb;
                end
            end
            tscPkg::StMem: begin
                if (opcode == tscPkg::OpLwd && !inputReady) begin
                    nextState = tscPkg::StMem;  // Load still waiting
                end else begin
                    nextState = (opcode == tscPkg::OpLwd) ? tscPkg::StWb : tscPkg::StIf;
                end
            end
            default:       nextState = tscPkg::StIf;  // WB and unused codes
        endcase
    end

    always_comb begin
        ctrl   = '0;
        readM  = 1'b0;
        writeM = 1'b0;
        case (state)
            tscPkg::StIf: begin
                if (!isHalted) begin
                    readM            = 1'b1;
                    ctrl.irWrite     = inputReady;  // Capture on ready edge
                    ctrl.pcWrite     = inputReady;  // PC + 1 only once
                    ctrl.aluSrcB     = tscPkg::SrcOne;
                    ctrl.aluOp       = tscPkg::AluAdd;
                    ctrl.pcSource    = tscPkg::PcAlu;
                end
            end
            tscPkg::StId: begin
                ctrl.abWrite     = 1'b1;
                ctrl.aluOutWrite = 1'b1;            // Branch target PC + imm
                ctrl.aluSrcB     = tscPkg::SrcImm;
                ctrl.aluOp       = tscPkg::AluAdd;
                if (opcode == tscPkg::OpJmp) begin
                    ctrl.pcWrite  = 1'b1;
                    ctrl.pcSource = tscPkg::PcJump;
                end else if (isRtype && func == tscPkg::FuncJpr) begin
                    ctrl.pcWrite  = 1'b1;
                    ctrl.pcSource = tscPkg::PcReg;
                end
                ctrl.outWrite = isRtype && (func == tscPkg::FuncWwd);
            end
            tscPkg::StEx: begin
                ctrl.aluSrcA     = 1'b1;
                ctrl.aluOutWrite = !isBranch;       // Keep target for branches
                ctrl.pcWriteCond = isBranch && bcond;
                ctrl.pcSource    = tscPkg::PcAluOut;
                ctrl.aluSrcB     = tscPkg::SrcImm;
                case (opcode)
                    tscPkg::OpOri: begin
                        ctrl.zeroExt = 1'b1;
                        ctrl.aluOp   = tscPkg::AluOr;
                    end
                    tscPkg::OpLhi: begin
                        ctrl.aluSrcB = tscPkg::SrcHigh;
                        ctrl.aluOp   = tscPkg::AluPassB;
                    end
                    tscPkg::OpRtype: begin
                        ctrl.aluSrcB = tscPkg::SrcReg;
                        case (func)
                            tscPkg::FuncSub: ctrl.aluOp = tscPkg::AluSub;
                            tscPkg::FuncAnd: ctrl.aluOp = tscPkg::AluAnd;
                            tscPkg::FuncOrr: ctrl.aluOp = tscPkg::AluOr;
                            tscPkg::FuncNot: ctrl.aluOp = tscPkg::AluNot;
                            tscPkg::FuncTcp: ctrl.aluOp = tscPkg::AluTcp;
                            tscPkg::FuncShl: ctrl.aluOp = tscPkg::AluShl;
                            tscPkg::FuncShr: ctrl.aluOp = tscPkg::AluShr;
                            default:         ctrl.aluOp = tscPkg::AluAdd;
                        endcase
                    end
                    default: ctrl.aluOp = tscPkg::AluAdd;  // ADI and address calc
                endcase
            end
            tscPkg::StMem: begin
                ctrl.iorD = 1'b1;
                if (opcode == tscPkg::OpLwd) begin
                    readM         = 1'b1;
                    ctrl.mdrWrite = inputReady;
                end else begin
                    writeM = 1'b1;  // Single cycle store
                end
            end
            tscPkg::StWb: begin
                ctrl.regWrite = 1'b1;
                ctrl.memToReg = opcode == tscPkg::OpLwd;
                ctrl.regDst   = isRtype;                  // rd for R-type, else rt
            end
            default: ctrl = '0;
        endcase
    end

endmodule

// ==== src/tscCpu.sv ====
/*
 * TSC multi-cycle CPU top level
 * Sequencer and datapath joined to the memory bus and status ports
 */
`timescale 1ns/100ps

module tscCpu #(
    parameter logic [tscPkg::WordSize-1:0] ResetPc = '0  // First fetch address
) (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic [tscPkg::WordSize-1:0] readData,
    input  logic                        inputReady,
    output tscPkg::memReq_t             mem,
    output logic [tscPkg::WordSize-1:0] numInst,
    output logic [tscPkg::WordSize-1:0] outputPort,
    output logic                        isHalted
);

    tscPkg::ctrl_t  ctrl;   // Control word of the current state
    tscPkg::instr_t instr;  // IR contents for decode
    logic           bcond;  // Branch condition from A and B

    tscSequencer i_sequencer (
        .clk        (clk),
        .reset_n    (reset_n),
        .instr      (instr),
        .bcond      (bcond),
        .inputReady (inputReady),
        .ctrl       (ctrl),
        .readM      (mem.readM),
        .writeM     (mem.writeM),
        .numInst    (numInst),
        .isHalted   (isHalted)
    );

    tscDatapath #(.ResetPc(ResetPc)) i_datapath (
        .clk        (clk),
        .reset_n    (reset_n),
        .ctrl       (ctrl),
        .readData   (readData),
        .instr      (instr),
        .bcond      (bcond),
        .address    (mem.address),    // PC or ALUOut
        .writeData  (mem.writeData),  // Store data from B
        .outputPort (outputPort)
    );

endmodule

// ==== verif/tscCpu_props.sv ====
/*
 * Concurrent checks on the TSC memory bus, retired count and halt flag
 * Bound into every tscCpu instance
 */
`timescale 1ns/100ps

module tscCpuProps (
    input logic                        clk,
    input logic                        reset_n,
    input logic                        inputReady,
    input tscPkg::memReq_t             mem,
    input logic [tscPkg::WordSize-1:0] numInst,
    input logic                        isHalted
);

    int failCount = 0;  // Read by the testbench at the end

    busExclusive: assert property (@(posedge clk) disable iff (!reset_n)
        !(mem.readM && mem.writeM))
    else begin
        failCount++;
        $error("readM and writeM are high in the same cycle");
    end

    storePulse: assert property (@(posedge clk) disable iff (!reset_n)
        mem.writeM |=> !mem.writeM)  // One-cycle store level
    else begin
        failCount++;
        $error("writeM stayed high for more than one cycle");
    end

    haltSticky: assert property (@(posedge clk) disable iff (!reset_n)
        isHalted |=> isHalted)
    else begin
        failCount++;
        $error("isHalted fell after being set");
    end

    haltIdle: assert property (@(posedge clk) disable iff (!reset_n)
        isHalted |-> !mem.readM && !mem.writeM)  // No bus traffic once halted
    else begin
        failCount++;
        $error("Memory access after halt");
    end

    countStep: assert property (@(posedge clk) disable iff (!reset_n)
        1'b1 |=> (numInst == $past(numInst)) || (numInst == $past(numInst) + 16'd1))
    else begin
        failCount++;
        $error("numInst jumped by more than one or went down");
    end

    addrHold: assert property (@(posedge clk) disable iff (!reset_n)
        mem.readM && !inputReady |=> $stable(mem.address))  // Stalled read
    else begin
        failCount++;
        $error("address changed while a read was waiting for inputReady");
    end

endmodule

bind tscCpu tscCpuProps i_props (
    .clk        (clk),
    .reset_n    (reset_n),
    .inputReady (inputReady),
    .mem        (mem),
    .numInst    (numInst),
    .isHalted   (isHalted)
);

// ==== verif/tscCpuTb.sv ====
/*
 * TSC CPU testbench: clock, reset, memory model with random ready delay,
 * test program, WWD output checks and closing report
 */
`timescale 1ns/100ps

module tscCpuTb;

    localparam int          HaltTimeout = 2000;      // Cycles
    localparam logic [15:0] PoisonValue = 16'hDEAD;  // $3 on skipped paths
    localparam logic [7:0]  StoreAddr   = 8'hF5;     // $3 (0x00F0) + 5

    logic                        clk;
    logic                        reset_n;
    logic [tscPkg::WordSize-1:0] readData;
    logic                        inputReady;
    tscPkg::memReq_t             mem;
    logic [tscPkg::WordSize-1:0] numInst;
    logic [tscPkg::WordSize-1:0] outputPort;
    logic                        isHalted;

    logic [15:0] memory [256];
    logic [15:0] expected [$];  // WWD values in program order
    logic [15:0] lastOut;
    int          loadAddr;
    int          executedCount;  // Words on the taken program path
    int          outIndex;
    int          outErrors;
    int          errorCount;
    int          seed = 32'h586077b8;

    tscCpu #(.ResetPc(16'h0000)) i_dut (
        .clk        (clk),
        .reset_n    (reset_n),
        .readData   (readData),
        .inputReady (inputReady),
        .mem        (mem),
        .numInst    (numInst),
        .outputPort (outputPort),
        .isHalted   (isHalted)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    function automatic logic [15:0] encodeR(input logic [1:0] rs, input logic [1:0] rt,
                                            input logic [1:0] rd, input logic [5:0] func);
        return {tscPkg::OpRtype, rs, rt, rd, func};
    endfunction

    function automatic logic [15:0] encodeI(input logic [3:0] op, input logic [1:0] rs,
                                            input logic [1:0] rt, input logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic placeWord(input logic [15:0] word);
        memory[loadAddr] = word;
        loadAddr++;
        executedCount++;  // Counts toward numInst
    endtask

    task automatic placeSkipped(input logic [15:0] word);
        memory[loadAddr] = word;  // Never reached
        loadAddr++;
    endtask

    task automatic placeOutput(input logic [1:0] rs, input logic [15:0] value);
        placeWord(encodeR(rs, 2'd0, 2'd0, tscPkg::FuncWwd));
        expected.push_back(value);
    endtask

    // ADI $0,$0,1 then WWD $0
    task automatic placeMarker(input logic [15:0] value);
        placeWord(encodeI(tscPkg::OpAdi, 2'd0, 2'd0, 8'h01));
        placeOutput(2'd0, value);
    endtask

    task automatic loadProgram();
        logic [15:0] poison;
        poison = encodeR(2'd3, 2'd0, 2'd0, tscPkg::FuncWwd);
        for (int i = 0; i < 256; i++) begin
            memory[i] = 16'(i) ^ 16'hA5A5;
        end
        loadAddr      = 0;
        executedCount = 0;
        placeWord(encodeI(tscPkg::OpLhi, 2'd0, 2'd1, 8'h12));  // $1 = 0x1200
        placeWord(encodeI(tscPkg::OpOri, 2'd1, 2'd1, 8'h34));  // $1 = 0x1234
        placeOutput(2'd1, 16'h1234);
        placeWord(encodeI(tscPkg::OpAdi, 2'd1, 2'd2, 8'hFF));  // $2 = $1 - 1
        placeOutput(2'd2, 16'h1233);
        placeWord(encodeI(tscPkg::OpOri, 2'd0, 2'd3, 8'hF0));  // Zero extended
        placeWord(encodeR(2'd1, 2'd3, 2'd0, tscPkg::FuncAdd));
        placeOutput(2'd0, 16'h1324);
        placeWord(encodeR(2'd1, 2'd3, 2'd0, tscPkg::FuncSub));
        placeOutput(2'd0, 16'h1144);
        placeWord(encodeR(2'd1, 2'd3, 2'd0, tscPkg::FuncAnd));
        placeOutput(2'd0, 16'h0030);
        placeWord(encodeR(2'd1, 2'd3, 2'd0, tscPkg::FuncOrr));
        placeOutput(2'd0, 16'h12F4);
        placeWord(encodeR(2'd1, 2'd0, 2'd0, tscPkg::FuncNot));
        placeOutput(2'd0, 16'hEDCB);
        placeWord(encodeR(2'd1, 2'd0, 2'd0, tscPkg::FuncTcp));
        placeOutput(2'd0, 16'hEDCC);
        placeWord(encodeR(2'd0, 2'd0, 2'd0, tscPkg::FuncShr));  // Negative operand
        placeOutput(2'd0, 16'hF6E6);
        placeWord(encodeR(2'd1, 2'd0, 2'd0, tscPkg::FuncShl));
        placeOutput(2'd0, 16'h2468);
        placeWord(encodeI(tscPkg::OpSwd, 2'd3, 2'd1, 8'h05));  // M[0xF5] = $1
        placeWord(encodeI(tscPkg::OpLwd, 2'd3, 2'd2, 8'h05));  // $2 = M[0xF5]
        placeOutput(2'd2, 16'h1234);
        placeWord(encodeI(tscPkg::OpLhi, 2'd0, 2'd3, 8'hDE));
        placeWord(encodeI(tscPkg::OpOri, 2'd3, 2'd3, 8'hAD));  // $3 = poison
        // Taken branches skip one poison word and not-taken ones fall into a marker
        placeWord(encodeI(tscPkg::OpBne, 2'd1, 2'd3, 8'h01));
        placeSkipped(poison);
        placeMarker(16'h2469);
        placeWord(encodeI(tscPkg::OpBne, 2'd1, 2'd2, 8'h02));
        placeMarker(16'h246A);
        placeWord(encodeI(tscPkg::OpBeq, 2'd1, 2'd2, 8'h01));
        placeSkipped(poison);
        placeMarker(16'h246B);
        placeWord(encodeI(tscPkg::OpBeq, 2'd1, 2'd3, 8'h02));
        placeMarker(16'h246C);
        placeWord(encodeI(tscPkg::OpBgz, 2'd1, 2'd0, 8'h01));
        placeSkipped(poison);
        placeMarker(16'h246D);
        placeWord(encodeI(tscPkg::OpBgz, 2'd3, 2'd0, 8'h02));
        placeMarker(16'h246E);
        placeWord(encodeI(tscPkg::OpBlz, 2'd3, 2'd0, 8'h01));
        placeSkipped(poison);
        placeMarker(16'h246F);
        placeWord(encodeI(tscPkg::OpBlz, 2'd1, 2'd0, 8'h02));
        placeMarker(16'h2470);
        placeWord({tscPkg::OpJmp, 12'(loadAddr + 2)});  // Over one poison word
        placeSkipped(poison);
        placeMarker(16'h2471);
        placeWord(encodeI(tscPkg::OpLhi, 2'd0, 2'd2, 8'h00));
        placeWord(encodeI(tscPkg::OpOri, 2'd2, 2'd2, 8'(loadAddr + 4)));  // JPR target
        placeWord(encodeR(2'd2, 2'd0, 2'd0, tscPkg::FuncJpr));
        placeSkipped(poison);
        placeSkipped(poison);
        placeMarker(16'h2472);
        placeWord(encodeR(2'd0, 2'd0, 2'd0, tscPkg::FuncHlt));
        placeSkipped(poison);  // Must never run after halt
    endtask

    // Memory model driven 1 ns after each rising edge
    initial begin : memoryModel
        int delayLeft;
        readData   = '0;
        inputReady = 1'b0;
        delayLeft  = -1;
        forever begin
            @(posedge clk);
            #1;
            if (inputReady) begin
                inputReady = 1'b0;  // Access ended on this edge
                delayLeft  = -1;
            end
            if (mem.writeM) begin
                memory[mem.address[7:0]] = mem.writeData;
            end
            if (mem.readM) begin
                if (delayLeft < 0) begin
                    delayLeft = $random(seed) & 3;  // 0 to 3 wait cycles
                end
                if (delayLeft == 0) begin
                    inputReady = 1'b1;
                    readData   = memory[mem.address[7:0]];
                end else begin
                    delayLeft--;
                end
            end
        end
    end

    // Each new outputPort value is one WWD since consecutive values differ
    always @(negedge clk) begin
        if (reset_n && outputPort !== lastOut) begin
            assert (outputPort != PoisonValue)
            else begin
                outErrors++;
                $display("Poisoned WWD on a skipped path reached outputPort at %0t", $realtime);
            end
            assert (outIndex < expected.size())
            else begin
                outErrors++;
                $display("More WWD outputs than the program produces at %0t", $realtime);
            end
            if (outIndex < expected.size()) begin
                assert (outputPort == expected[outIndex])
                else begin
                    outErrors++;
                    $display("[ERROR] %0t outputPort: expected %h, actual %h",
                             $realtime, expected[outIndex], outputPort);
                end
            end
            outIndex++;
            lastOut = outputPort;
        end
    end

    initial begin : mainSequence
        int cycles;
        $timeformat(-9, 1, " ns", 0);
        reset_n    = 1'b0;
        errorCount = 0;
        outErrors  = 0;
        outIndex   = 0;
        lastOut    = '0;
        loadProgram();
        repeat (8) @(posedge clk);
        #1;
        reset_n = 1'b1;
        cycles  = 0;
        while (!isHalted && cycles < HaltTimeout) begin
            @(posedge clk);
            #1;  // Sample after the edge has settled
            cycles++;
        end
        if (!isHalted) begin
            errorCount++;
            $display("Timeout: the CPU did not halt within %0d cycles", HaltTimeout);
        end
        repeat (4) @(posedge clk);  // Idle cycles for the halt properties
        #1;
        assert (outIndex == expected.size())
        else begin
            errorCount++;
            $display("Only %0d of %0d WWD outputs were seen", outIndex, expected.size());
        end
        assert (numInst == 16'(executedCount))
        else begin
            errorCount++;
            $display("[ERROR] %0t numInst: expected %0d, actual %0d",
                     $realtime, executedCount, numInst);
        end
        assert (memory[StoreAddr] == 16'h1234)
        else begin
            errorCount++;
            $display("[ERROR] %0t memory[0xF5]: expected %h, actual %h",
                     $realtime, 16'h1234, memory[StoreAddr]);
        end
        errorCount += outErrors;
        $display("Closing report: %0d testbench errors, %0d assertion failures",
                 errorCount, i_dut.i_props.failCount);
        if (errorCount == 0 && i_dut.i_props.failCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
src/tscPkg.sv
src/tscAlu.sv
src/tscRegFile.sv
src/tscDatapath.sv
src/tscSequencer.sv
src/tscCpu.sv
verif/tscCpu_props.sv
verif/tscCpuTb.sv

// ==== Makefile ====
# Verilator flow for the TSC CPU testbench
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = tscCpuTb
FILELIST  = verilog.f
OBJDIR    = obj_dir
LOG       = sim.log
RUNARGS   = +verilator+error+limit+1000
PASS      = No errors

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) $(RUNARGS) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
